// ==== verilog/st7735_pkg.sv ====
package st7735_pkg;

    // one item for the serial writer, 8-bit items sit in the low byte
    typedef struct packed {
        logic [15:0] data;
        logic        dc;
        logic        wide;
        logic        last;
    } lcd_item_t;

    // one row of the power-up table
    // dc low marks a command byte
    typedef struct packed {
        logic       dc;
        logic [7:0] value;
    } init_entry_t;

    // sequencer phases, the delay phase serves both waits
    typedef enum logic [1:0] {
        PH_RESET_LOW,
        PH_DELAY,
        PH_INIT,
        PH_WINDOW
    } seq_phase_t;

    // default panel size in pixels
    localparam logic [15:0] DEF_WIDTH  = 16'd160;
    localparam logic [15:0] DEF_HEIGHT = 16'd120;

    // default waits in LCD_CLK cycles
    // about 10 ms reset low and 120 ms delay at 12 MHz
    localparam int DEF_RESET_CYCLES = 120_000;
    localparam int DEF_DELAY_CYCLES = 1_440_000;

    localparam int WAIT_CNT_W = 24;

    // window commands
    localparam logic [7:0] CMD_CASET = 8'h2A;
    localparam logic [7:0] CMD_RASET = 8'h2B;
    localparam logic [7:0] CMD_RAMWR = 8'h2C;

    // caset group, raset group, ramwr
    localparam int WIN_LEN = 11;
    localparam int WIN_IDX_W = 4;
    localparam logic [WIN_IDX_W-1:0] WIN_LAST = WIN_IDX_W'(WIN_LEN - 1);

    // shortened power-up table
    localparam int INIT_LEN = 11;
    localparam int INIT_IDX_W = $clog2(INIT_LEN);
    localparam logic [INIT_IDX_W-1:0] INIT_LAST = INIT_IDX_W'(INIT_LEN - 1);

    // the panel needs time after sleep-out before the next command
    localparam logic [INIT_IDX_W-1:0] SLEEP_OUT_IDX = '0;

    localparam init_entry_t INIT_TABLE [INIT_LEN] = '{
        // sleep out
        '{1'b0, 8'h11},
        // frame rate control, normal mode
        '{1'b0, 8'hB1},
        '{1'b1, 8'h01},
        '{1'b1, 8'h2C},
        '{1'b1, 8'h2D},
        // 16 bit per pixel
        '{1'b0, 8'h3A},
        '{1'b1, 8'h05},
        // memory access control, orientation
        '{1'b0, 8'h36},
        '{1'b1, 8'hC0},
        // inversion on
        '{1'b0, 8'h21},
        // display on
        '{1'b0, 8'h29}
    };

endpackage

// ==== verilog/lcd_cmd_sequencer.sv ====
`timescale 1ns/1ps

module lcd_cmd_sequencer #(
    parameter int width        = st7735_pkg::DEF_WIDTH,
    parameter int height       = st7735_pkg::DEF_HEIGHT,
    parameter int reset_cycles = st7735_pkg::DEF_RESET_CYCLES,
    parameter int delay_cycles = st7735_pkg::DEF_DELAY_CYCLES
) (
    input  logic                  LCD_CLK,
    input  logic                  reset,
    output logic                  lcd_reset,
    output st7735_pkg::lcd_item_t cmd_item,
    output logic                  cmd_valid,
    input  logic                  cmd_ready
);

    st7735_pkg::seq_phase_t                 phase;
    logic [st7735_pkg::WAIT_CNT_W-1:0]      wait_cnt;
    logic [st7735_pkg::WAIT_CNT_W-1:0]      reset_end;
    logic [st7735_pkg::WAIT_CNT_W-1:0]      delay_end;
    logic [st7735_pkg::INIT_IDX_W-1:0]      init_idx;
    logic [st7735_pkg::WIN_IDX_W-1:0]       win_idx;
    logic [15:0]                            col_end;
    logic [15:0]                            row_end;
    logic [7:0]                             win_byte;
    logic                                   win_dc;
    logic                                   xfer;
    st7735_pkg::init_entry_t                init_row;

    assign reset_end = reset_cycles[st7735_pkg::WAIT_CNT_W-1:0];
    assign delay_end = delay_cycles[st7735_pkg::WAIT_CNT_W-1:0];
    assign col_end   = 16'(width - 1);
    assign row_end   = 16'(height - 1);

    assign cmd_valid = (phase == st7735_pkg::PH_INIT) || (phase == st7735_pkg::PH_WINDOW);
    assign xfer      = cmd_valid & cmd_ready;
    assign init_row  = st7735_pkg::INIT_TABLE[init_idx];

    // window group, start addresses are always zero
    always_comb begin
        win_byte = 8'h00;
        win_dc   = 1'b1;
        case (win_idx)
            4'd0: begin
                win_byte = st7735_pkg::CMD_CASET;
                win_dc   = 1'b0;
            end
            4'd3: win_byte = col_end[15:8];
            4'd4: win_byte = col_end[7:0];
            4'd5: begin
                win_byte = st7735_pkg::CMD_RASET;
                win_dc   = 1'b0;
            end
            4'd8: win_byte = row_end[15:8];
            4'd9: win_byte = row_end[7:0];
            4'd10: begin
                win_byte = st7735_pkg::CMD_RAMWR;
                win_dc   = 1'b0;
            end
            default: ;
        endcase
    end

    always_comb begin
        cmd_item = '0;
        if (phase == st7735_pkg::PH_WINDOW) begin
            cmd_item.data = {8'h00, win_byte};
            cmd_item.dc   = win_dc;
            // ramwr hands the writer over to the pixel stream
            cmd_item.last = (win_idx == st7735_pkg::WIN_LAST);
        end else begin
            cmd_item.data = {8'h00, init_row.value};
            cmd_item.dc   = init_row.dc;
        end
    end

    always_ff @(posedge LCD_CLK) begin
        if (reset) begin
            phase     <= st7735_pkg::PH_RESET_LOW;
            lcd_reset <= 1'b1;
            wait_cnt  <= '0;
            init_idx  <= '0;
            win_idx   <= '0;
        end else begin
            case (phase)
                st7735_pkg::PH_RESET_LOW: begin
                    if (wait_cnt == reset_end) begin
                        lcd_reset <= 1'b1;
                        wait_cnt  <= 1;
                        phase     <= st7735_pkg::PH_DELAY;
                    end else begin
                        lcd_reset <= 1'b0;
                        wait_cnt  <= wait_cnt + 1'b1;
                    end
                end
                st7735_pkg::PH_DELAY: begin
                    // first wait or the one after sleep-out
                    if (wait_cnt == delay_end) begin
                        wait_cnt <= '0;
                        phase    <= st7735_pkg::PH_INIT;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                st7735_pkg::PH_INIT: begin
                    if (xfer) begin
                        if (init_idx == st7735_pkg::INIT_LAST) begin
                            win_idx <= '0;
                            phase   <= st7735_pkg::PH_WINDOW;
                        end else begin
                            init_idx <= init_idx + 1'b1;
                        end
                        if (init_idx == st7735_pkg::SLEEP_OUT_IDX) begin
                            wait_cnt <= 1;
                            phase    <= st7735_pkg::PH_DELAY;
                        end
                    end
                end
                default: begin
                    // window group repeats once the frame is done
                    if (xfer) begin
                        if (win_idx == st7735_pkg::WIN_LAST) begin
                            win_idx <= '0;
                        end else begin
                            win_idx <= win_idx + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    // panel reset pin only pulled low during the reset phase
    reset_pin_phase: assert property (@(posedge LCD_CLK) disable iff (reset)
        !lcd_reset |-> (phase == st7735_pkg::PH_RESET_LOW));

endmodule

// ==== verilog/lcd_pixel_source.sv ====
`timescale 1ns/1ps

module lcd_pixel_source #(
    parameter int width  = st7735_pkg::DEF_WIDTH,
    parameter int height = st7735_pkg::DEF_HEIGHT
) (
    input  logic                  LCD_CLK,
    input  logic                  reset,
    input  logic [15:0]           fill_color,
    input  logic                  pix_ready,
    input  logic                  pix_mode,
    output st7735_pkg::lcd_item_t pix_item,
    output logic                  pix_valid
);

    logic [15:0] color_q;
    logic [15:0] col;
    logic [15:0] row;
    logic [15:0] col_end;
    logic [15:0] row_end;
    logic        mode_d;
    logic        at_last;
    logic        xfer;

    assign col_end = 16'(width - 1);
    assign row_end = 16'(height - 1);
    assign at_last = (col == col_end) && (row == row_end);

    // colour is latched on the mode edge, valid follows a cycle later
    assign pix_valid = pix_mode & mode_d;
    assign xfer      = pix_valid & pix_ready;
    assign pix_item  = '{data: color_q, dc: 1'b1, wide: 1'b1, last: at_last};

    always_ff @(posedge LCD_CLK) begin
        if (pix_mode && !mode_d) begin
            color_q <= fill_color;
        end
    end

    always_ff @(posedge LCD_CLK) begin
        if (reset) begin
            mode_d <= 1'b0;
            col    <= '0;
            row    <= '0;
        end else begin
            mode_d <= pix_mode;
            if (xfer) begin
                if (at_last) begin
                    col <= '0;
                    row <= '0;
                end else if (col == col_end) begin
                    col <= '0;
                    row <= row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    // writer must leave pixel mode after the final pixel
    no_pixel_past_frame: assert property (@(posedge LCD_CLK) disable iff (reset)
        (xfer && at_last) |=> !pix_valid);

endmodule

// ==== verilog/lcd_spi_writer.sv ====
`timescale 1ns/1ps

module lcd_spi_writer (
    input  logic                  LCD_CLK,
    input  logic                  reset,
    input  st7735_pkg::lcd_item_t cmd_item,
    input  logic                  cmd_valid,
    output logic                  cmd_ready,
    input  st7735_pkg::lcd_item_t pix_item,
    input  logic                  pix_valid,
    output logic                  pix_ready,
    output logic                  pix_mode,
    output logic                  sck,
    output logic                  mosi,
    output logic                  dc,
    output logic                  cs
);

    st7735_pkg::lcd_item_t sel_item;
    logic                  sel_valid;
    logic                  ready_q;
    logic                  load;
    logic                  busy;
    logic [15:0]           shifter;
    logic [4:0]            bits_left;

    // pixel mode listens to the pixel stream only
    assign sel_item  = pix_mode ? pix_item : cmd_item;
    assign sel_valid = pix_mode ? pix_valid : cmd_valid;
    assign cmd_ready = ready_q & ~pix_mode;
    assign pix_ready = ready_q & pix_mode;
    assign load      = ready_q & sel_valid;

    // byte items are moved up to the top for msb first
    always_ff @(posedge LCD_CLK) begin
        if (load) begin
            shifter <= sel_item.wide ? sel_item.data : {sel_item.data[7:0], 8'h00};
        end else if (busy && sck) begin
            shifter <= {shifter[14:0], 1'b0};
        end
    end

    always_ff @(posedge LCD_CLK) begin
        if (reset) begin
            pix_mode  <= 1'b0;
            busy      <= 1'b0;
            ready_q   <= 1'b0;
            bits_left <= '0;
            sck       <= 1'b0;
            mosi      <= 1'b0;
            dc        <= 1'b0;
            cs        <= 1'b1;
        end else if (load) begin
            busy      <= 1'b1;
            ready_q   <= 1'b0;
            bits_left <= sel_item.wide ? 5'd16 : 5'd8;
            sck       <= 1'b0;
            mosi      <= sel_item.wide ? sel_item.data[15] : sel_item.data[7];
            dc        <= sel_item.dc;
            cs        <= 1'b0;
            // ramwr enters pixel mode and the final pixel leaves it
            if (sel_item.last) begin
                pix_mode <= ~pix_mode;
            end
        end else if (busy) begin
            if (!sck) begin
                sck <= 1'b1;
                // ready during the last high phase keeps items back to back
                ready_q <= (bits_left == 5'd1);
            end else if (bits_left == 5'd1) begin
                // release the bus when nothing is waiting
                busy      <= 1'b0;
                bits_left <= '0;
                sck       <= 1'b0;
                cs        <= 1'b1;
            end else begin
                sck       <= 1'b0;
                bits_left <= bits_left - 1'b1;
                mosi      <= shifter[14];
            end
        end else begin
            ready_q <= 1'b1;
        end
    end

    sck_quiet_when_deselected: assert property (@(posedge LCD_CLK) disable iff (reset)
        cs |-> !sck);

    // no new item may start before the last bit of the current one
    dc_stable_in_item: assert property (@(posedge LCD_CLK) disable iff (reset)
        (!cs && bits_left != 5'd1) |=> $stable(dc));

endmodule

// ==== verilog/st7735_ctrl.sv ====
`timescale 1ns/1ps

module st7735_ctrl #(
    parameter int width        = st7735_pkg::DEF_WIDTH,
    parameter int height       = st7735_pkg::DEF_HEIGHT,
    parameter int reset_cycles = st7735_pkg::DEF_RESET_CYCLES,
    parameter int delay_cycles = st7735_pkg::DEF_DELAY_CYCLES
) (
    input  logic        LCD_CLK,
    input  logic        reset,
    input  logic [15:0] fill_color,
    output logic        lcd_reset,
    output logic        sck,
    output logic        mosi,
    output logic        dc,
    output logic        cs
);

    st7735_pkg::lcd_item_t cmd_item;
    logic                  cmd_valid;
    logic                  cmd_ready;
    st7735_pkg::lcd_item_t pix_item;
    logic                  pix_valid;
    logic                  pix_ready;
    logic                  pix_mode;

    // reset pulse, init table and window commands
    lcd_cmd_sequencer #(
        .width        (width),
        .height       (height),
        .reset_cycles (reset_cycles),
        .delay_cycles (delay_cycles)
    ) u_seq (
        .LCD_CLK   (LCD_CLK),
        .reset     (reset),
        .lcd_reset (lcd_reset),
        .cmd_item  (cmd_item),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready)
    );

    // solid colour frame
    lcd_pixel_source #(
        .width  (width),
        .height (height)
    ) u_pix (
        .LCD_CLK    (LCD_CLK),
        .reset      (reset),
        .fill_color (fill_color),
        .pix_ready  (pix_ready),
        .pix_mode   (pix_mode),
        .pix_item   (pix_item),
        .pix_valid  (pix_valid)
    );

    lcd_spi_writer u_spi (
        .LCD_CLK   (LCD_CLK),
        .reset     (reset),
        .cmd_item  (cmd_item),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .pix_item  (pix_item),
        .pix_valid (pix_valid),
        .pix_ready (pix_ready),
        .pix_mode  (pix_mode),
        .sck       (sck),
        .mosi      (mosi),
        .dc        (dc),
        .cs        (cs)
    );

endmodule

// ==== tb/tb_st7735_ctrl.sv ====
`timescale 1ns/1ps

module tb_st7735_ctrl;

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int RESET_HOLD  = 16;
    localparam int SEED        = 72;

    // panel setup under test
    localparam int W         = 4;
    localparam int H         = 3;
    localparam int RESET_CYC = 20;
    localparam int DELAY_CYC = 50;

    // layout of the stimulus file
    localparam int INIT_ROWS  = 11;
    localparam int NUM_FRAMES = 3;
    localparam int STIM_LEN   = INIT_ROWS + NUM_FRAMES;

    localparam int WIN_LEN  = 11;
    localparam int BYTE_CYC = 16;
    localparam int PIX_CYC  = 32;

    // reset, both waits, init bytes, then window plus frame three times, doubled
    localparam int TIMEOUT_CYCLES = 2 * (RESET_HOLD + RESET_CYC + 2 * DELAY_CYC
        + INIT_ROWS * BYTE_CYC + NUM_FRAMES * (WIN_LEN * BYTE_CYC + W * H * PIX_CYC));

    logic        LCD_CLK;
    logic        reset;
    logic [15:0] fill_color;
    logic        lcd_reset;
    logic        sck;
    logic        mosi;
    logic        dc;
    logic        cs;

    logic [15:0] stim_mem [STIM_LEN];

    st7735_pkg::lcd_item_t cap_q[$];

    int pass_count       = 0;
    int fail_count       = 0;
    int cycle_cnt        = 0;
    int reset_low_cycles = 0;
    int sck_while_idle   = 0;
    int dc_changes       = 0;
    int reset_bad        = 0;

    // capture state
    logic                  sck_prev = 1'b0;
    logic                  item_dc  = 1'b0;
    logic [15:0]           shift_in = '0;
    int                    bit_cnt  = 0;
    int                    pix_left = 0;
    int                    byte_cnt = 0;
    st7735_pkg::lcd_item_t got_item;

    st7735_ctrl #(
        .width        (W),
        .height       (H),
        .reset_cycles (RESET_CYC),
        .delay_cycles (DELAY_CYC)
    ) UUT (
        .LCD_CLK    (LCD_CLK),
        .reset      (reset),
        .fill_color (fill_color),
        .lcd_reset  (lcd_reset),
        .sck        (sck),
        .mosi       (mosi),
        .dc         (dc),
        .cs         (cs)
    );

    initial begin
        LCD_CLK = 1'b0;
        forever #(CLK_PERIOD / 2) LCD_CLK = ~LCD_CLK;
    end

    task automatic check_byte(input string name, input st7735_pkg::init_entry_t exp,
                              input st7735_pkg::init_entry_t act);
        if (act === exp) begin
            pass_count++;
            $display("ok %s dc=%b byte=%h", name, act.dc, act.value);
        end else begin
            fail_count++;
            $display("mismatch %s expected dc=%b byte=%h actual dc=%b byte=%h",
                     name, exp.dc, exp.value, act.dc, act.value);
        end
    endtask

    task automatic check_pixel(input string name, input st7735_pkg::lcd_item_t exp,
                               input st7735_pkg::lcd_item_t act);
        if (act === exp) begin
            pass_count++;
            $display("ok %s dc=%b color=%h", name, act.dc, act.data);
        end else begin
            fail_count++;
            $display("mismatch %s expected dc=%b color=%h actual dc=%b color=%h",
                     name, exp.dc, exp.data, act.dc, act.data);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act == exp) begin
            pass_count++;
            $display("ok %s count=%0d", name, act);
        end else begin
            fail_count++;
            $display("mismatch %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    // the watchdog ends the run if the DUT stalls
    task automatic next_item(output st7735_pkg::lcd_item_t it);
        while (cap_q.size() == 0) begin
            @(posedge LCD_CLK);
        end
        it = cap_q.pop_front();
    endtask

    // window group from the panel rules, start addresses zero
    function automatic st7735_pkg::init_entry_t window_byte(input int idx);
        st7735_pkg::init_entry_t e;
        e.dc    = 1'b1;
        e.value = 8'h00;
        case (idx)
            0: begin
                e.dc    = 1'b0;
                e.value = 8'h2A;
            end
            4: e.value = 8'(W - 1);
            5: begin
                e.dc    = 1'b0;
                e.value = 8'h2B;
            end
            9: e.value = 8'(H - 1);
            10: begin
                e.dc    = 1'b0;
                e.value = 8'h2C;
            end
            default: ;
        endcase
        return e;
    endfunction

    // SPI capture, sampled on the falling LCD_CLK edge where all pins are settled
    always @(negedge LCD_CLK) begin
        if (reset) begin
            sck_prev = 1'b0;
            bit_cnt  = 0;
        end else begin
            if (!lcd_reset) begin
                reset_low_cycles++;
            end
            if (cs && sck) begin
                sck_while_idle++;
            end
            if (sck && !sck_prev && !cs) begin
                if (bit_cnt == 0) begin
                    item_dc = dc;
                end else if (dc !== item_dc) begin
                    dc_changes++;
                end
                shift_in = {shift_in[14:0], mosi};
                bit_cnt++;
                if (bit_cnt == ((pix_left > 0) ? 16 : 8)) begin
                    got_item      = '0;
                    got_item.dc   = item_dc;
                    got_item.wide = (pix_left > 0);
                    got_item.data = (pix_left > 0) ? shift_in : {8'h00, shift_in[7:0]};
                    cap_q.push_back(got_item);
                    bit_cnt = 0;
                    if (pix_left > 0) begin
                        pix_left--;
                    end else begin
                        byte_cnt++;
                        // a memory write after init starts a pixel run
                        if (byte_cnt > INIT_ROWS && !item_dc && shift_in[7:0] == 8'h2C) begin
                            pix_left = W * H;
                        end
                    end
                end
            end
            sck_prev = sck;
        end
    end

    initial begin : watchdog
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge LCD_CLK);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, the DUT did not finish three frames", cycle_cnt);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin : main
        st7735_pkg::lcd_item_t   it;
        st7735_pkg::init_entry_t exp_byte;
        st7735_pkg::init_entry_t act_byte;
        st7735_pkg::lcd_item_t   exp_pix;
        int                      change_at;

        void'($urandom(SEED));
        $readmemh("tb/lcd_stimulus.txt", stim_mem);
        reset      = 1'b1;
        fill_color = stim_mem[INIT_ROWS];

        repeat (RESET_HOLD) begin
            @(posedge LCD_CLK);
            #(DRIVE_DELAY);
            if (cs !== 1'b1 || sck !== 1'b0 || lcd_reset !== 1'b1) begin
                reset_bad++;
            end
        end
        reset = 1'b0;
        check_count("reset_state_bad_cycles", 0, reset_bad);

        for (int i = 0; i < INIT_ROWS; i++) begin
            next_item(it);
            exp_byte.dc    = stim_mem[i][8];
            exp_byte.value = stim_mem[i][7:0];
            act_byte.dc    = it.dc;
            act_byte.value = it.data[7:0];
            check_byte($sformatf("init_%0d", i), exp_byte, act_byte);
        end

        for (int f = 0; f < NUM_FRAMES; f++) begin
            for (int k = 0; k < WIN_LEN; k++) begin
                next_item(it);
                act_byte.dc    = it.dc;
                act_byte.value = it.data[7:0];
                check_byte($sformatf("frame%0d_win_%0d", f, k), window_byte(k), act_byte);
            end
            change_at = 2 + int'($urandom % 8);
            exp_pix   = '0;
            exp_pix.data = stim_mem[INIT_ROWS + f];
            exp_pix.dc   = 1'b1;
            exp_pix.wide = 1'b1;
            for (int p = 0; p < W * H; p++) begin
                next_item(it);
                check_pixel($sformatf("frame%0d_pix_%0d", f, p), exp_pix, it);
                // next colour mid-frame, it only shows in the following frame
                if (p == change_at && f < NUM_FRAMES - 1) begin
                    @(posedge LCD_CLK);
                    #(DRIVE_DELAY);
                    fill_color = stim_mem[INIT_ROWS + f + 1];
                end
            end
        end

        check_count("lcd_reset_low_cycles", RESET_CYC, reset_low_cycles);
        check_count("sck_pulses_while_cs_high", 0, sck_while_idle);
        check_count("dc_changes_within_item", 0, dc_changes);

        $display("tests done: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== tb/lcd_stimulus.txt ====
// init rows: one word each, bit 8 is the dc flag, bits 7..0 the byte on the wire
// then one 16-bit fill colour per frame, frames 0 to 2
// sleep out
011
// frame rate control and its three parameters
0B1
101
12C
12D
// pixel format, 16 bit
03A
105
// memory access control
036
1C0
// inversion on
021
// display on
029
// fill colour of frame 0, red
F800
// frame 1, green
07E0
// frame 2, blue
001F

// ==== all.f ====
verilog/st7735_pkg.sv
verilog/lcd_cmd_sequencer.sv
verilog/lcd_pixel_source.sv
verilog/lcd_spi_writer.sv
verilog/st7735_ctrl.sv
tb/tb_st7735_ctrl.sv

// ==== run.sh ====
#!/bin/sh
# build and run the ST7735 controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_st7735_ctrl -Mdir "$OBJ" -f all.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/Vtb_st7735_ctrl" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q -F '*** PASSED ***' "$LOG"; then
    exit 0
fi
exit 1
